/* src/dbus_pkg.sv */
`default_nettype none

package dbus_pkg;

	// Bus and CPU word types.
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  byte_en_t;

	// Access size as issued by the CPU.
	typedef logic [1:0] access_size_t;

	localparam access_size_t SIZE_BYTE = 2'd0;
	localparam access_size_t SIZE_HALF = 2'd1;
	localparam access_size_t SIZE_WORD = 2'd2;

	// Memory model geometry.
	localparam int MEM_WORDS    = 8192;
	localparam int LINE_WORDS   = 4;
	localparam int MISS_PENALTY = 8;

	localparam logic [2:0] UNCACHED_SEG = 3'b101; // Top three address bits.

	localparam int WORD_AW = $clog2(MEM_WORDS);
	localparam int LINE_AW = WORD_AW - $clog2(LINE_WORDS);

	// Counts down the remaining stall cycles of a miss.
	typedef logic [$clog2(MISS_PENALTY)-1:0] pen_cnt_t;

	typedef enum logic {
		MEM_READY,
		MEM_MISS_WAIT
	} mem_state_e;

endpackage

`default_nettype wire

/* src/cpu_dbus_if.sv */
`default_nettype none

interface cpu_dbus_if;
	import dbus_pkg::*;

	logic     read;
	logic     write;
	addr_t    address;   // Word aligned.
	byte_en_t byteenable;
	data_t    wrdata;

	logic     stall;
	data_t    rddata;    // Valid the cycle after completion.

	modport master (
		output read,
		output write,
		output address,
		output byteenable,
		output wrdata,
		input  stall,
		input  rddata
	);

	modport slave (
		input  read,
		input  write,
		input  address,
		input  byteenable,
		input  wrdata,
		output stall,
		output rddata
	);

endinterface

`default_nettype wire

/* src/lsu_format.sv */
`default_nettype none

module lsu_format (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req,
	input  logic                  we,
	input  dbus_pkg::access_size_t size,
	input  logic                  sign_ext,
	input  dbus_pkg::addr_t       addr,
	input  dbus_pkg::data_t       wdata,
	output dbus_pkg::data_t       rdata,
	output logic                  rvalid,
	output logic                  misaligned,
	cpu_dbus_if.master            dbus
);
	import dbus_pkg::*;

	logic [1:0] offset;
	logic       aligned;
	byte_en_t   be;
	data_t      st_data;

	// Read info queue, entry 0 in the memory pipe, entry 1 returning.
	// Each entry holds {offset, size, sign_ext}.
	logic [4:0] rq_meta [2];
	logic [1:0] rq_vld;

	logic [1:0]   ret_off;
	access_size_t ret_size;
	logic         ret_sext;
	data_t        shifted;

	assign offset = addr[1:0];

	always_comb begin
		case (size)
			SIZE_BYTE: begin
				aligned = 1'b1;
				be      = 4'b0001 << offset;
				st_data = {4{wdata[7:0]}};
			end
			SIZE_HALF: begin
				aligned = ~offset[0];
				be      = 4'b0011 << offset;
				st_data = {2{wdata[15:0]}};
			end
			default: begin // Word, and the unused code.
				aligned = (offset == 2'b00);
				be      = 4'b1111;
				st_data = wdata;
			end
		endcase
	end

	// Misaligned requests never reach the bus.
	assign dbus.read       = req & ~we & aligned;
	assign dbus.write      = req & we & aligned;
	assign dbus.address    = {addr[$bits(addr_t)-1:2], 2'b00};
	assign dbus.byteenable = be;
	assign dbus.wrdata     = st_data;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			misaligned <= 1'b0;
		end else begin
			misaligned <= req & ~aligned & ~dbus.stall;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rq_vld <= 2'b00;
		end else if (dbus.stall) begin
			rq_vld[1] <= 1'b0; // Returning entry lasts one cycle.
		end else begin
			rq_vld <= {rq_vld[0], dbus.read};
		end
	end

	always_ff @(posedge clk) begin
		if (~dbus.stall) begin
			rq_meta[1] <= rq_meta[0];
			rq_meta[0] <= {offset, size, sign_ext};
		end
	end

	assign ret_off  = rq_meta[1][4:3];
	assign ret_size = rq_meta[1][2:1];
	assign ret_sext = rq_meta[1][0];

	// Bring the addressed lane down to bit 0.
	assign shifted = dbus.rddata >> {ret_off, 3'b000};

	always_comb begin
		case (ret_size)
			SIZE_BYTE: rdata = {{24{ret_sext & shifted[7]}}, shifted[7:0]};
			SIZE_HALF: rdata = {{16{ret_sext & shifted[15]}}, shifted[15:0]};
			default:   rdata = dbus.rddata;
		endcase
	end

	assign rvalid = rq_vld[1];

endmodule

`default_nettype wire

/* src/dbus_router.sv */
`default_nettype none

module dbus_router (
	input  logic       clk,
	input  logic       rst,
	cpu_dbus_if.slave  dbus_cpu,
	cpu_dbus_if.master dbus_cached,
	cpu_dbus_if.master dbus_uncached
);
	import dbus_pkg::*;

	logic req_unc;  // Current request targets the uncached segment.
	logic pend_unc; // Access held in the memory pipe went uncached.
	logic ret_unc;  // Read returning this cycle came from the uncached port.

	assign req_unc = (dbus_cpu.address[$bits(addr_t)-1 -: 3] == UNCACHED_SEG);

	// Strobes go to one port only.
	assign dbus_cached.read    = dbus_cpu.read & ~req_unc;
	assign dbus_cached.write   = dbus_cpu.write & ~req_unc;
	assign dbus_uncached.read  = dbus_cpu.read & req_unc;
	assign dbus_uncached.write = dbus_cpu.write & req_unc;

	assign dbus_cached.address    = dbus_cpu.address;
	assign dbus_cached.byteenable = dbus_cpu.byteenable;
	assign dbus_cached.wrdata     = dbus_cpu.wrdata;

	assign dbus_uncached.address    = dbus_cpu.address;
	assign dbus_uncached.byteenable = dbus_cpu.byteenable;
	assign dbus_uncached.wrdata     = dbus_cpu.wrdata;

	// Port ownership follows the memory pipe one stage at a time.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pend_unc <= 1'b0;
			ret_unc  <= 1'b0;
		end else if (~dbus_cpu.stall) begin
			pend_unc <= (dbus_cpu.read | dbus_cpu.write) & req_unc;
			ret_unc  <= pend_unc;
		end
	end

	assign dbus_cpu.stall  = pend_unc ? dbus_uncached.stall : dbus_cached.stall;
	assign dbus_cpu.rddata = ret_unc ? dbus_uncached.rddata : dbus_cached.rddata;

endmodule

`default_nettype wire

/* src/line_touch_mem.sv */
`default_nettype none

module line_touch_mem (
	input  logic      clk,
	input  logic      rst,
	input  logic      miss_en,
	cpu_dbus_if.slave dbus,
	cpu_dbus_if.slave dbus_uncached
);
	import dbus_pkg::*;

	data_t mem [MEM_WORDS];
	logic [2**LINE_AW-1:0] resident;

	mem_state_e state;
	pen_cnt_t   pen_cnt;
	logic       stall;

	// Incoming request, merged from both ports.
	logic     in_read;
	logic     in_write;
	logic     in_unc;
	addr_t    in_addr;
	byte_en_t in_be;
	data_t    in_wdata;
	logic [LINE_AW-1:0] in_line;
	logic     in_resident;
	logic     in_miss;

	// Pipe stage.
	logic     p_read;
	logic     p_write;
	logic     p_unc;
	addr_t    p_addr;
	byte_en_t p_be;
	data_t    p_wdata;
	logic [LINE_AW-1:0] p_line;
	logic [WORD_AW-1:0] p_word;

	logic  complete;
	data_t old_word;
	data_t merged;

	assign in_unc   = dbus_uncached.read | dbus_uncached.write;
	assign in_read  = dbus.read | dbus_uncached.read;
	assign in_write = dbus.write | dbus_uncached.write;
	assign in_addr  = in_unc ? dbus_uncached.address : dbus.address;
	assign in_be    = in_unc ? dbus_uncached.byteenable : dbus.byteenable;
	assign in_wdata = in_unc ? dbus_uncached.wrdata : dbus.wrdata;

	assign in_line = in_addr[WORD_AW+1 -: LINE_AW];
	assign p_line  = p_addr[WORD_AW+1 -: LINE_AW];
	assign p_word  = p_addr[WORD_AW+1:2];

	assign stall    = (state == MEM_MISS_WAIT);
	assign complete = ~stall & (p_read | p_write);

	// A line filled at this very edge already counts as resident.
	assign in_resident = resident[in_line] | (complete & ~p_unc & (p_line == in_line));
	assign in_miss     = miss_en & (in_read | in_write) & (in_unc | ~in_resident);

	// Only the port that owns the held access sees the stall.
	assign dbus.stall          = stall & ~p_unc;
	assign dbus_uncached.stall = stall & p_unc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			p_read  <= 1'b0;
			p_write <= 1'b0;
			p_unc   <= 1'b0;
		end else if (~stall) begin
			p_read  <= in_read;
			p_write <= in_write;
			p_unc   <= in_unc;
		end
	end

	always_ff @(posedge clk) begin
		if (~stall) begin
			p_addr  <= in_addr;
			p_be    <= in_be;
			p_wdata <= in_wdata;
		end
	end

	// Miss decided as the request enters the pipe.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= MEM_READY;
			pen_cnt <= '0;
		end else begin
			case (state)
				MEM_READY: begin
					if (in_miss) begin
						state   <= MEM_MISS_WAIT;
						pen_cnt <= pen_cnt_t'(MISS_PENALTY - 1);
					end
				end
				MEM_MISS_WAIT: begin
					if (pen_cnt == '0)
						state <= MEM_READY;
					else
						pen_cnt <= pen_cnt - 1'b1;
				end
				default: state <= MEM_READY;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			resident <= '0;
		end else if (complete & ~p_unc) begin
			resident[p_line] <= 1'b1; // Uncached never fills.
		end
	end

	assign old_word = mem[p_word];

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			merged[8*i +: 8] = p_be[i] ? p_wdata[8*i +: 8] : old_word[8*i +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (complete & p_write)
			mem[p_word] <= merged;
		if (complete & p_read & ~p_unc)
			dbus.rddata <= old_word;
		if (complete & p_read & p_unc)
			dbus_uncached.rddata <= old_word;
	end

endmodule

`default_nettype wire

/* src/dbus_top.sv */
`default_nettype none

module dbus_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   miss_en,
	input  logic                   req,
	input  logic                   we,
	input  dbus_pkg::access_size_t size,
	input  logic                   sign_ext,
	input  dbus_pkg::addr_t        addr,
	input  dbus_pkg::data_t        wdata,
	output logic                   busy,
	output dbus_pkg::data_t        rdata,
	output logic                   rvalid,
	output logic                   misaligned
);

	cpu_dbus_if dbus_cpu ();
	cpu_dbus_if dbus_cached ();
	cpu_dbus_if dbus_uncached ();

	lsu_format u_lsu (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.we         (we),
		.size       (size),
		.sign_ext   (sign_ext),
		.addr       (addr),
		.wdata      (wdata),
		.rdata      (rdata),
		.rvalid     (rvalid),
		.misaligned (misaligned),
		.dbus       (dbus_cpu)
	);

	dbus_router u_router (
		.clk           (clk),
		.rst           (rst),
		.dbus_cpu      (dbus_cpu),
		.dbus_cached   (dbus_cached),
		.dbus_uncached (dbus_uncached)
	);

	line_touch_mem u_mem (
		.clk           (clk),
		.rst           (rst),
		.miss_en       (miss_en),
		.dbus          (dbus_cached),
		.dbus_uncached (dbus_uncached)
	);

	assign busy = dbus_cpu.stall; // Stall of the owning port.

endmodule

`default_nettype wire

/* verif/dbus_properties.sv */
`default_nettype none

module dbus_properties (
	input logic               clk,
	input logic               rst,
	input logic               read,
	input logic               write,
	input logic               stall,
	input dbus_pkg::addr_t    address,
	input dbus_pkg::byte_en_t byteenable,
	input dbus_pkg::data_t    wrdata
);
	import dbus_pkg::*;

	int stall_run; // Consecutive edges with stall high.

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			stall_run <= 0;
		else if (stall)
			stall_run <= stall_run + 1;
		else
			stall_run <= 0;
	end

	assert property (@(posedge clk) disable iff (rst) !(read && write))
		else $error("read and write were high in the same cycle");

	// A request presented under stall is held to the next edge.
	assert property (@(posedge clk) disable iff (rst)
		stall && (read || write) |=> $stable(read) && $stable(write)
			&& $stable(address) && $stable(byteenable) && $stable(wrdata))
		else $error("request changed while stall was high");

	assert property (@(posedge clk) disable iff (rst) stall_run <= MISS_PENALTY + 1)
		else $error("stall lasted longer than the miss penalty");

endmodule

bind line_touch_mem dbus_properties u_props (
	.clk        (clk),
	.rst        (rst),
	.read       (in_read),
	.write      (in_write),
	.stall      (stall),
	.address    (in_addr),
	.byteenable (in_be),
	.wrdata     (in_wdata)
);

`default_nettype wire

/* verif/dbus_tb.sv */
`default_nettype none

module dbus_tb;
	import dbus_pkg::*;

	localparam int    DRIVE_DLY      = 2;
	localparam int    RVALID_TIMEOUT = 4 * MISS_PENALTY;
	localparam int    RAND_OPS       = 400;
	localparam int    MEM_BYTES      = MEM_WORDS * 4;
	localparam int    WIN_WORDS      = 64;
	localparam addr_t WIN_BASE       = 32'h0000_0800;
	localparam addr_t UNC_BASE       = {UNCACHED_SEG, 29'd0};

	logic         clk;
	logic         rst;
	logic         miss_en;
	logic         req;
	logic         we;
	access_size_t size;
	logic         sign_ext;
	addr_t        addr;
	data_t        wdata;
	logic         busy;
	data_t        rdata;
	logic         rvalid;
	logic         misaligned;

	logic [7:0]  ref_mem [MEM_BYTES]; // Byte image of the word array.
	logic        line_res [2**LINE_AW];
	data_t       exp_q [$];
	string       name_q [$];
	logic [31:0] rng;

	dbus_top UUT (.*);

	always #10 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input data_t expected, input data_t actual);
		if (actual !== expected)
			abort_run($sformatf("Error: %s expected %08h actual %08h", name, expected, actual));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int byte_index(input addr_t a);
		return int'(a % MEM_BYTES); // Uncached alias lands on the same bytes.
	endfunction

	function automatic data_t fill_word(input addr_t a);
		return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
	endfunction

	// Expected load result in little-endian order with optional sign extension.
	function automatic data_t ref_load(input access_size_t sz, input logic sext, input addr_t a);
		int    b;
		data_t v;
		b = byte_index(a);
		case (sz)
			SIZE_BYTE: v = {{24{sext & ref_mem[b][7]}}, ref_mem[b]};
			SIZE_HALF: v = {{16{sext & ref_mem[b+1][7]}}, ref_mem[b+1], ref_mem[b]};
			default:   v = {ref_mem[b+3], ref_mem[b+2], ref_mem[b+1], ref_mem[b]};
		endcase
		return v;
	endfunction

	task automatic ref_store(input access_size_t sz, input addr_t a, input data_t wd);
		int b;
		int n;
		b = byte_index(a);
		n = (sz == SIZE_BYTE) ? 1 : ((sz == SIZE_HALF) ? 2 : 4);
		for (int i = 0; i < n; i++)
			ref_mem[b + i] = wd[8*i +: 8];
	endtask

	// Issues one access and waits out busy and, for a read, rvalid.
	task automatic access(input string name, input logic wr, input access_size_t sz,
		input logic sext, input addr_t a, input data_t wd);
		logic is_unc;
		logic ok;
		logic exp_miss;
		int   line_idx;
		int   busy_cycles;
		int   edges;
		is_unc   = (a[31:29] == UNCACHED_SEG);
		ok       = (sz == SIZE_BYTE) || (sz == SIZE_HALF && !a[0]) || (a[1:0] == 2'b00);
		line_idx = byte_index(a) / (4 * LINE_WORDS);
		exp_miss = ok && miss_en && (is_unc || !line_res[line_idx]);
		@(posedge clk);
		#DRIVE_DLY;
		req      = 1'b1;
		we       = wr;
		size     = sz;
		sign_ext = sext;
		addr     = a;
		wdata    = wd;
		if (ok && !wr) begin
			exp_q.push_back(ref_load(sz, sext, a));
			name_q.push_back(name);
		end
		@(posedge clk);
		#DRIVE_DLY;
		req   = 1'b0;
		edges = 1;
		check_value({name, " misaligned flag"}, data_t'(!ok), data_t'(misaligned));
		busy_cycles = 0;
		while (busy) begin
			busy_cycles++;
			if (busy_cycles > MISS_PENALTY + 2)
				abort_run($sformatf("%s: busy stayed high far past the miss penalty", name));
			@(posedge clk);
			#DRIVE_DLY;
			edges++;
		end
		check_value({name, " busy cycles"}, data_t'(exp_miss ? MISS_PENALTY : 0),
			data_t'(busy_cycles));
		if (ok && !wr) begin
			while (!rvalid) begin
				if (edges > RVALID_TIMEOUT)
					abort_run($sformatf("%s: read data never came back", name));
				@(posedge clk);
				#DRIVE_DLY;
				edges++;
			end
			check_value({name, " read latency"}, data_t'(exp_miss ? 2 + MISS_PENALTY : 2),
				data_t'(edges));
		end
		if (ok && wr)
			ref_store(sz, a, wd);
		if (ok && !is_unc)
			line_res[line_idx] = 1'b1; // Cached accesses fill the line.
	endtask

	// Word store to a cached address, with a load of the same word held behind it.
	task automatic store_then_held_load(input string name, input addr_t a, input data_t wd);
		int   line_idx;
		logic exp_miss;
		int   busy_cycles;
		int   edges;
		line_idx = byte_index(a) / (4 * LINE_WORDS);
		exp_miss = miss_en && !line_res[line_idx];
		@(posedge clk);
		#DRIVE_DLY;
		req      = 1'b1;
		we       = 1'b1;
		size     = SIZE_WORD;
		sign_ext = 1'b0;
		addr     = a;
		wdata    = wd;
		@(posedge clk);
		#DRIVE_DLY;
		we = 1'b0; // The load waits while busy is high.
		ref_store(SIZE_WORD, a, wd);
		exp_q.push_back(ref_load(SIZE_WORD, 1'b0, a));
		name_q.push_back(name);
		busy_cycles = 0;
		while (busy) begin
			busy_cycles++;
			if (busy_cycles > MISS_PENALTY + 2)
				abort_run($sformatf("%s: busy stayed high far past the miss penalty", name));
			@(posedge clk);
			#DRIVE_DLY;
		end
		check_value({name, " busy cycles"}, data_t'(exp_miss ? MISS_PENALTY : 0),
			data_t'(busy_cycles));
		@(posedge clk);
		#DRIVE_DLY;
		req   = 1'b0;
		edges = 1;
		while (!rvalid) begin
			if (edges > RVALID_TIMEOUT)
				abort_run($sformatf("%s: read data never came back", name));
			@(posedge clk);
			#DRIVE_DLY;
			edges++;
		end
		check_value({name, " read latency"}, 32'd2, data_t'(edges));
		line_res[line_idx] = 1'b1;
	endtask

	always @(negedge clk) begin
		if (!rst && rvalid) begin
			if (exp_q.size() == 0)
				abort_run("rvalid rose with no read outstanding");
			else
				check_value(name_q.pop_front(), exp_q.pop_front(), rdata);
		end
	end

	initial begin
		access_size_t r_size;
		addr_t        r_addr;
		clk      = 1'b0;
		rst      = 1'b1;
		miss_en  = 1'b0;
		req      = 1'b0;
		we       = 1'b0;
		size     = SIZE_WORD;
		sign_ext = 1'b0;
		addr     = '0;
		wdata    = '0;
		rng      = 32'h7a3c_08f0;
		for (int i = 0; i < 2**LINE_AW; i++)
			line_res[i] = 1'b0;
		repeat (16) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;

		for (int i = 0; i < 8; i++)
			access("word store", 1'b1, SIZE_WORD, 1'b0, 32'h100 + 4*i, fill_word(32'h100 + 4*i));
		for (int i = 0; i < 8; i++)
			access("word load", 1'b0, SIZE_WORD, 1'b0, 32'h100 + 4*i, '0);

		access("merge base", 1'b1, SIZE_WORD, 1'b0, 32'h200, 32'h1122_3344);
		access("byte store", 1'b1, SIZE_BYTE, 1'b0, 32'h201, 32'h0000_0080);
		access("half store", 1'b1, SIZE_HALF, 1'b0, 32'h202, 32'h0000_fe01);
		access("merged word", 1'b0, SIZE_WORD, 1'b0, 32'h200, '0);
		for (int off = 0; off < 4; off++) begin
			access("byte load zext", 1'b0, SIZE_BYTE, 1'b0, 32'h200 + off, '0);
			access("byte load sext", 1'b0, SIZE_BYTE, 1'b1, 32'h200 + off, '0);
		end
		for (int off = 0; off < 4; off += 2) begin
			access("half load zext", 1'b0, SIZE_HALF, 1'b0, 32'h200 + off, '0);
			access("half load sext", 1'b0, SIZE_HALF, 1'b1, 32'h200 + off, '0);
		end

		// First touch of each fresh line misses.
		miss_en = 1'b1;
		for (int i = 0; i < 4; i++)
			access("line store", 1'b1, SIZE_WORD, 1'b0, 32'h400 + 4*i, fill_word(32'h400 + 4*i));
		access("line byte store", 1'b1, SIZE_BYTE, 1'b0, 32'h40b, 32'h0000_00c7);
		for (int i = 0; i < 4; i++)
			access("line load", 1'b0, SIZE_WORD, 1'b0, 32'h400 + 4*i, '0);
		access("second line store", 1'b1, SIZE_HALF, 1'b0, 32'h442, 32'h0000_8001);
		access("second line load", 1'b0, SIZE_HALF, 1'b1, 32'h442, '0);
		store_then_held_load("load held behind store miss", 32'h480, 32'h3c5a_96e1);

		access("uncached alias load", 1'b0, SIZE_WORD, 1'b0, UNC_BASE | 32'h404, '0);
		access("uncached store", 1'b1, SIZE_WORD, 1'b0, UNC_BASE | 32'h408, 32'hdead_beef);
		access("cached after uncached", 1'b0, SIZE_WORD, 1'b0, 32'h408, '0);
		access("uncached fresh store", 1'b1, SIZE_WORD, 1'b0, UNC_BASE | 32'h500, 32'h0bad_f00d);
		access("cached first touch", 1'b0, SIZE_WORD, 1'b0, 32'h500, '0);
		access("cached hit", 1'b0, SIZE_BYTE, 1'b1, 32'h503, '0);
		access("uncached again", 1'b0, SIZE_HALF, 1'b0, UNC_BASE | 32'h502, '0);

		miss_en = 1'b0;
		access("misalign base", 1'b1, SIZE_WORD, 1'b0, 32'h600, fill_word(32'h600));
		access("misaligned half store", 1'b1, SIZE_HALF, 1'b0, 32'h601, 32'h0000_ffff);
		access("misaligned word store", 1'b1, SIZE_WORD, 1'b0, 32'h602, 32'hffff_ffff);
		access("misaligned word load", 1'b0, SIZE_WORD, 1'b0, 32'h603, '0);
		miss_en = 1'b1;
		access("misaligned uncached", 1'b1, SIZE_WORD, 1'b0, UNC_BASE | 32'h601, '0);
		access("unchanged after misalign", 1'b0, SIZE_WORD, 1'b0, 32'h600, '0);

		// Fill the window uncached, so its lines stay non-resident.
		miss_en = 1'b0;
		for (int i = 0; i < WIN_WORDS; i++)
			access("window fill", 1'b1, SIZE_WORD, 1'b0, UNC_BASE | (WIN_BASE + 4*i),
				fill_word(WIN_BASE + 4*i));
		miss_en = 1'b1;
		for (int n = 0; n < RAND_OPS; n++) begin
			rng = xorshift32(rng);
			if (rng[31:29] == 3'd0)
				miss_en = ~miss_en;
			r_size = (rng[9:8] == 2'd3) ? SIZE_WORD : access_size_t'(rng[9:8]);
			r_addr = WIN_BASE + addr_t'({rng[17:12], rng[11:10]});
			if (rng[18])
				r_addr = r_addr | UNC_BASE;
			access($sformatf("random op %0d", n), rng[19], r_size, rng[20], r_addr,
				xorshift32(rng ^ 32'h1f2e_3d4c));
		end

		repeat (4) @(posedge clk);
		#DRIVE_DLY;
		if (exp_q.size() != 0) begin
			abort_run("reads were still outstanding at the end of the run");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* list.f */
src/dbus_pkg.sv
src/cpu_dbus_if.sv
src/lsu_format.sv
src/dbus_router.sv
src/line_touch_mem.sv
src/dbus_top.sv
verif/dbus_properties.sv
verif/dbus_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module dbus_tb -f list.f -o Vdbus_tb

output="$(./obj_dir/Vdbus_tb || true)"
printf '%s\n' "$output"

if grep -q "TEST PASSED" <<< "$output"; then
	exit 0
fi
exit 1
